//--- hdl/ghtPkg.sv
// GHT table definitions
`default_nettype none

package ghtPkg;

    // table geometry
    localparam int IndexWidth = 16;
    localparam int HistWidth = 8;
    localparam int CounterWidth = 2;
    localparam int NumBanks = 8;
    localparam int RowsPerBank = 32;
    localparam int ColsPerRow = 256;

    typedef logic [IndexWidth-1:0] tableIndex;
    typedef logic [CounterWidth-1:0] counterVal;
    typedef logic [2:0] bankSel;
    typedef logic [4:0] rowSel;
    typedef logic [7:0] colSel;

    // valid doubles as the write strobe
    typedef struct packed {
        logic valid;
        tableIndex index;
        counterVal counter;
    } writeReq;

    // bank is index bits 7:6 joined with bit 0
    function automatic bankSel bankOf(tableIndex idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic rowSel rowOf(tableIndex idx);
        return idx[5:1];
    endfunction

    function automatic colSel colOf(tableIndex idx);
        return idx[15:8];
    endfunction

endpackage

`default_nettype wire

//--- hdl/ghtBank.sv
// GHT counter bank
`default_nettype none

module ghtBank (
    input  wire                           clk,
    input  wire ghtPkg::writeReq          bankWrite,
    input  wire [$bits(ghtPkg::rowSel):0] clearRow,
    input  wire ghtPkg::rowSel            readRow,
    input  wire ghtPkg::colSel            readCol,
    output ghtPkg::counterVal             readCounter
);
    import ghtPkg::*;

    // one row holds all columns of a row index
    counterVal [ColsPerRow-1:0] rows [RowsPerBank];

    logic clearEn;
    rowSel clearAt;
    rowSel writeRow;
    colSel writeCol;
    logic dataEn;

    // top bit is the clear flag, the rest the row to clear
    assign clearEn = clearRow[$bits(rowSel)];
    assign clearAt = clearRow[$bits(rowSel)-1:0];

    assign writeRow = rowOf(bankWrite.index);
    assign writeCol = colOf(bankWrite.index);
    assign dataEn = bankWrite.valid && !clearEn;

    always_ff @(posedge clk) begin
        if (clearEn) begin
            rows[clearAt] <= '0;
        end else if (dataEn) begin
            rows[writeRow][writeCol] <= bankWrite.counter;
        end
    end

    // write-first bypass
    always_comb begin
        if (clearEn && readRow == clearAt) begin
            readCounter = '0;
        end else if (dataEn && readRow == writeRow && readCol == writeCol) begin
            readCounter = bankWrite.counter;
        end else begin
            readCounter = rows[readRow][readCol];
        end
    end

    // sweep clear carries its own row on the write bus with no payload
    clearIsPureSweep: assert property (
        @(posedge clk)
        clearEn |-> bankWrite.valid && writeRow == clearAt && bankWrite.counter == '0
    ) else $error("bank got a data write together with a row clear");

endmodule

`default_nettype wire

//--- hdl/ghtLookup.sv
// GHT lookup stage
`default_nettype none

module ghtLookup (
    input  wire                                           clk,
    input  wire                                           rst,
    input  wire                                           lookupEn,
    input  wire ghtPkg::tableIndex                        fetchAddr,
    input  wire [ghtPkg::HistWidth-1:0]                   history,
    input  wire ghtPkg::counterVal [ghtPkg::NumBanks-1:0] bankCounters,
    output ghtPkg::rowSel                                 readRow,
    output ghtPkg::colSel                                 readCol,
    output logic                                          predValid,
    output ghtPkg::counterVal                             predCounter
);
    import ghtPkg::*;

    tableIndex hashedIndex;
    tableIndex lookupIndex;

    // history lands on the column bits
    assign hashedIndex = fetchAddr ^ {history, {(IndexWidth - HistWidth){1'b0}}};

    always_ff @(posedge clk) begin
        if (lookupEn) begin
            lookupIndex <= hashedIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= lookupEn;
        end
    end

    assign readRow = rowOf(lookupIndex);
    assign readCol = colOf(lookupIndex);

    // every bank reads the same row and column, keep the one addressed
    assign predCounter = bankCounters[bankOf(lookupIndex)];

endmodule

`default_nettype wire

//--- hdl/ghtWriteSched.sv
// GHT write scheduler
`default_nettype none

module ghtWriteSched #(
    parameter int NumSweepRows = ghtPkg::RowsPerBank
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire ghtPkg::writeReq                  wrPort0,
    input  wire ghtPkg::writeReq                  wrPort1,
    output ghtPkg::writeReq [ghtPkg::NumBanks-1:0] bankWrites,
    output logic [$bits(ghtPkg::rowSel):0]        clearRow,
    output logic                                  initBusy
);
    import ghtPkg::*;

    localparam int CountWidth = (NumSweepRows > 1) ? $clog2(NumSweepRows) : 1;

    logic [CountWidth-1:0] sweepCount;
    rowSel sweepRow;
    tableIndex sweepIndex;
    writeReq spill;
    bankSel bank0;
    bankSel bank1;
    bankSel spillBank;
    logic direct0;
    logic direct1;
    logic conflict1;
    logic save0;
    logic save1;

    // clear sweep, one row per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            initBusy <= 1'b1;
            sweepCount <= '0;
        end else if (initBusy) begin
            sweepCount <= sweepCount + 1'b1;
            if (sweepCount == CountWidth'(NumSweepRows - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

    assign sweepRow = rowSel'(sweepCount);
    assign clearRow = {initBusy, sweepRow};

    always_comb begin
        sweepIndex = '0;
        sweepIndex[$bits(rowSel):1] = sweepRow;
    end

    assign bank0 = bankOf(wrPort0.index);
    assign bank1 = bankOf(wrPort1.index);
    assign spillBank = bankOf(spill.index);

    // spill owns its bank this cycle, port 0 beats port 1
    assign direct0 = !initBusy && wrPort0.valid && !(spill.valid && bank0 == spillBank);
    assign save0 = !initBusy && wrPort0.valid && !direct0;
    assign conflict1 = (wrPort0.valid && bank1 == bank0) || (spill.valid && bank1 == spillBank);
    assign direct1 = !initBusy && wrPort1.valid && !conflict1;
    assign save1 = !initBusy && wrPort1.valid && conflict1;

    always_ff @(posedge clk) begin
        if (rst) begin
            spill.valid <= 1'b0;
        end else if (save1) begin
            spill <= wrPort1;
        end else if (save0) begin
            spill <= wrPort0;
        end else begin
            spill.valid <= 1'b0;
        end
    end

    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            bankWrites[b] = '0;
            if (initBusy) begin
                bankWrites[b].valid = 1'b1;
                bankWrites[b].index = sweepIndex;
            end else if (spill.valid && spillBank == bankSel'(b)) begin
                bankWrites[b] = spill;
            end else if (direct0 && bank0 == bankSel'(b)) begin
                bankWrites[b] = wrPort0;
            end else if (direct1 && bank1 == bankSel'(b)) begin
                bankWrites[b] = wrPort1;
            end
        end
    end

    singleSpill: assert property (
        @(posedge clk) disable iff (rst)
        !(save0 && save1)
    ) else $error("two writes need the spill entry in one cycle");

endmodule

`default_nettype wire

//--- hdl/ghtPredictor.sv
// GHT branch direction predictor
`default_nettype none

module ghtPredictor (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         lookupEn,
    input  wire ghtPkg::tableIndex      fetchAddr,
    input  wire [ghtPkg::HistWidth-1:0] history,
    input  wire ghtPkg::writeReq        wrPort0,
    input  wire ghtPkg::writeReq        wrPort1,
    output logic                        predValid,
    output ghtPkg::counterVal           predCounter,
    output logic                        initBusy
);
    import ghtPkg::*;

    rowSel readRow;
    colSel readCol;
    counterVal [NumBanks-1:0] bankCounters;
    writeReq [NumBanks-1:0] bankWrites;
    logic [$bits(rowSel):0] clearRow;

    ghtLookup lookup (
        .clk          (clk),
        .rst          (rst),
        .lookupEn     (lookupEn),
        .fetchAddr    (fetchAddr),
        .history      (history),
        .bankCounters (bankCounters),
        .readRow      (readRow),
        .readCol      (readCol),
        .predValid    (predValid),
        .predCounter  (predCounter)
    );

    ghtWriteSched #(
        .NumSweepRows (RowsPerBank)
    ) writeSched (
        .clk        (clk),
        .rst        (rst),
        .wrPort0    (wrPort0),
        .wrPort1    (wrPort1),
        .bankWrites (bankWrites),
        .clearRow   (clearRow),
        .initBusy   (initBusy)
    );

    // banks share the read address and the sweep clear
    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        ghtBank bank (
            .clk         (clk),
            .bankWrite   (bankWrites[b]),
            .clearRow    (clearRow),
            .readRow     (readRow),
            .readCol     (readCol),
            .readCounter (bankCounters[b])
        );
    end

endmodule

`default_nettype wire

//--- dv/ghtTb.sv
// GHT predictor testbench
`default_nettype none

module ghtTb;
    timeunit 1ns;
    timeprecision 100ps;

    import ghtPkg::*;

    logic clk;
    logic rst;
    logic lookupEn;
    tableIndex fetchAddr;
    logic [HistWidth-1:0] history;
    writeReq wrPort0;
    writeReq wrPort1;
    logic predValid;
    counterVal predCounter;
    logic initBusy;

    integer seed = 5633;
    int errorCount = 0;
    int timeoutCount = 0;

    // reference model
    counterVal refMem [tableIndex];
    writeReq refSpill;
    tableIndex pendIndex;
    int edgesSinceReset;
    logic lastLookup;
    logic busyExp;
    logic validExp;
    counterVal expCounter;
    logic direct0;
    logic direct1;
    logic save0;
    logic save1;

    ghtPredictor dut_i (
        .clk         (clk),
        .rst         (rst),
        .lookupEn    (lookupEn),
        .fetchAddr   (fetchAddr),
        .history     (history),
        .wrPort0     (wrPort0),
        .wrPort1     (wrPort1),
        .predValid   (predValid),
        .predCounter (predCounter),
        .initBusy    (initBusy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [2:0] bankNum(tableIndex idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic counterVal storedAt(tableIndex idx);
        if (refMem.exists(idx)) begin
            return refMem[idx];
        end
        return '0;
    endfunction

    function automatic writeReq makeWrite(tableIndex idx, counterVal val);
        writeReq req;
        req.valid = 1'b1;
        req.index = idx;
        req.counter = val;
        return req;
    endfunction

    // spill drains first, port 0 wins a shared bank
    task automatic routeWrites();
        logic [2:0] spillBank;
        spillBank = bankNum(refSpill.index);
        direct0 = 1'b0;
        direct1 = 1'b0;
        save0 = 1'b0;
        save1 = 1'b0;
        if (!busyExp && wrPort0.valid) begin
            if (refSpill.valid && bankNum(wrPort0.index) == spillBank) begin
                save0 = 1'b1;
            end else begin
                direct0 = 1'b1;
            end
        end
        if (!busyExp && wrPort1.valid) begin
            if ((wrPort0.valid && bankNum(wrPort1.index) == bankNum(wrPort0.index)) ||
                (refSpill.valid && bankNum(wrPort1.index) == spillBank)) begin
                save1 = 1'b1;
            end else begin
                direct1 = 1'b1;
            end
        end
    endtask

    // commit the edge that just passed
    task automatic advanceModel();
        if (rst) begin
            refMem.delete();
            refSpill = '0;
            edgesSinceReset = 0;
            lastLookup = 1'b0;
            return;
        end
        if (!busyExp) begin
            if (refSpill.valid) begin
                refMem[refSpill.index] = refSpill.counter;
            end
            if (direct0) begin
                refMem[wrPort0.index] = wrPort0.counter;
            end
            if (direct1) begin
                refMem[wrPort1.index] = wrPort1.counter;
            end
        end
        refSpill = save1 ? wrPort1 : (save0 ? wrPort0 : writeReq'('0));
        lastLookup = lookupEn;
        if (lookupEn) begin
            pendIndex = fetchAddr ^ {history, 8'h00};
        end
        edgesSinceReset++;
    endtask

    // expected outputs for the cycle now starting, write-first
    task automatic previewCycle();
        busyExp = edgesSinceReset < 32;
        validExp = lastLookup;
        routeWrites();
        expCounter = storedAt(pendIndex);
        if (!busyExp && refSpill.valid && refSpill.index == pendIndex) begin
            expCounter = refSpill.counter;
        end
        if (direct0 && wrPort0.index == pendIndex) begin
            expCounter = wrPort0.counter;
        end
        if (direct1 && wrPort1.index == pendIndex) begin
            expCounter = wrPort1.counter;
        end
    endtask

    task automatic applyCycle(input writeReq w0, input writeReq w1, input logic look,
                              input tableIndex addr, input logic [HistWidth-1:0] hist);
        @(negedge clk);
        advanceModel();
        wrPort0 = w0;
        wrPort1 = w1;
        lookupEn = look;
        fetchAddr = addr;
        history = hist;
        previewCycle();
    endtask

    task automatic idleCycle();
        applyCycle('0, '0, 1'b0, '0, '0);
    endtask

    // history is random, the address makes the hash land on idx
    task automatic lookupAt(input tableIndex idx);
        logic [HistWidth-1:0] hist;
        int waited;
        hist = HistWidth'($random(seed));
        waited = 0;
        applyCycle('0, '0, 1'b1, idx ^ {hist, 8'h00}, hist);
        idleCycle();
        while (!predValid && waited < 4) begin
            idleCycle();
            waited++;
        end
        if (!predValid) begin
            timeoutCount++;
            $display("Timeout: no prediction came back for index %h", idx);
        end
    endtask

    busyCheck: assert property (@(posedge clk) disable iff (rst) initBusy == busyExp)
        else begin
            errorCount++;
            $display("Fail at time %0t: initBusy expected %0b got %0b",
                     $time, $sampled(busyExp), $sampled(initBusy));
        end

    validCheck: assert property (@(posedge clk) disable iff (rst) predValid == validExp)
        else begin
            errorCount++;
            $display("Fail at time %0t: predValid expected %0b got %0b",
                     $time, $sampled(validExp), $sampled(predValid));
        end

    counterCheck: assert property (
        @(posedge clk) disable iff (rst)
        predValid |-> predCounter == expCounter
    ) else begin
        errorCount++;
        $display("Fail at time %0t: predCounter expected %0d got %0d",
                 $time, $sampled(expCounter), $sampled(predCounter));
    end

    initial begin
        tableIndex idxA;
        tableIndex idxB;
        counterVal valA;
        counterVal valB;
        logic [HistWidth-1:0] hist;
        int waited;

        rst = 1'b1;
        lookupEn = 1'b0;
        fetchAddr = '0;
        history = '0;
        wrPort0 = '0;
        wrPort1 = '0;
        refSpill = '0;
        pendIndex = '0;
        edgesSinceReset = 0;
        lastLookup = 1'b0;
        previewCycle();
        repeat (2) idleCycle();
        rst = 1'b0;

        // dropped while the sweep runs
        idxA = tableIndex'($random(seed));
        // row 0 has already been swept
        idxA[5:1] = '0;
        applyCycle(makeWrite(idxA, 2'd3), '0, 1'b0, '0, '0);
        waited = 0;
        while (initBusy && waited < 40) begin
            idleCycle();
            waited++;
        end
        if (initBusy) begin
            timeoutCount++;
            $display("Timeout: initBusy never fell after reset");
        end
        lookupAt(idxA);
        repeat (4) lookupAt(tableIndex'($random(seed)));

        idxA = tableIndex'($random(seed));
        valA = counterVal'($random(seed)) | 2'b01;
        applyCycle(makeWrite(idxA, valA), '0, 1'b0, '0, '0);
        lookupAt(idxA);

        // two ports, two banks
        idxA = tableIndex'($random(seed));
        idxB = tableIndex'($random(seed));
        idxB[0] = ~idxA[0];
        valB = counterVal'($random(seed)) | 2'b10;
        applyCycle(makeWrite(idxA, valA), makeWrite(idxB, valB), 1'b0, '0, '0);
        lookupAt(idxA);
        lookupAt(idxB);

        // same bank, port 1 goes through the spill
        idxB = tableIndex'($random(seed));
        idxB[7:6] = idxA[7:6];
        idxB[0] = idxA[0];
        if (idxB == idxA) begin
            idxB[15:8] = ~idxA[15:8];
        end
        hist = HistWidth'($random(seed));
        // idxB result falls in the spill drain cycle
        applyCycle(makeWrite(idxA, valB), makeWrite(idxB, valA), 1'b1,
                   idxB ^ {hist, 8'h00}, hist);
        idleCycle();
        lookupAt(idxA);
        lookupAt(idxB);

        // write lands in the result cycle of the lookup
        hist = HistWidth'($random(seed));
        valA = storedAt(idxA) + 2'd1;
        applyCycle('0, '0, 1'b1, idxA ^ {hist, 8'h00}, hist);
        applyCycle(makeWrite(idxA, valA), '0, 1'b0, '0, '0);
        idleCycle();
        lookupAt(idxA);
        repeat (2) idleCycle();

        $display("Errors: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/ghtPkg.sv
hdl/ghtBank.sv
hdl/ghtLookup.sv
hdl/ghtWriteSched.sv
hdl/ghtPredictor.sv
dv/ghtTb.sv

//--- Makefile
SIM      := verilator
TOP      := ghtTb
FILELIST := build.f
FLAGS    := --binary --assert --timing -j 0
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
